// File: src.f
rtl/if_ft_pkg.sv
rtl/if_id_register.sv
rtl/tmr_voter.sv
rtl/breakage_monitor.sv
rtl/if_pipeline_ft.sv
bench/if_pipeline_ft_chk.sv
bench/if_pipeline_ft_tb.sv

// File: Makefile
# Verilator build and run of the fault tolerant IF/ID register

VERILATOR ?= verilator
TOP       ?= if_pipeline_ft_tb
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, pass only on the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/if_pipeline_ft_tb.sv
/* Fault tolerant IF/ID testbench */

module if_pipeline_ft_tb;

        localparam int NREP          = if_ft_pkg::NUM_REPLICAS;
        localparam int CLK_PERIOD    = 40;
        localparam int RESET_CYCLES  = 5;
        localparam int BREAK_TIMEOUT = 20;
        localparam int LEAK_ROUNDS   = 6;
        localparam int LEAK_GAP      = 4;

        localparam if_ft_pkg::fetch_t IDLE_FETCH = '0;

        logic                            clk;
        logic                            reset_i;
        if_ft_pkg::fetch_t [NREP-1:0]    fetch_i;
        if_ft_pkg::ctrl_t  [NREP-1:0]    ctrl_i;
        if_ft_pkg::replica_mask_t        set_broken_i;
        if_ft_pkg::id_stage_t            id_o;
        logic                            if_valid_o;
        if_ft_pkg::replica_mask_t        is_broken_o;
        logic                            err_detected_o;
        logic                            err_corrected_o;

        if_pipeline_ft UUT (
                .clk             (clk),
                .reset_i         (reset_i),
                .fetch_i         (fetch_i),
                .ctrl_i          (ctrl_i),
                .set_broken_i    (set_broken_i),
                .id_o            (id_o),
                .if_valid_o      (if_valid_o),
                .is_broken_o     (is_broken_o),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Stimulus helpers
        ////////////////////////////////////////////////////////////////////////////

        function automatic if_ft_pkg::fetch_t random_fetch();
                if_ft_pkg::fetch_t f;
                f.instr_valid   = 1'b1;
                f.fetch_valid   = 1'b1;
                f.instr         = if_ft_pkg::instr_t'($urandom);
                f.pc            = if_ft_pkg::pc_t'($urandom) & ~if_ft_pkg::pc_t'(1);
                f.is_compressed = ($urandom_range(1, 0) == 1);
                f.illegal_c     = ($urandom_range(1, 0) == 1);
                f.fetch_failed  = ($urandom_range(1, 0) == 1);
                return f;
        endfunction

        function automatic if_ft_pkg::ctrl_t make_ctrl(input logic ready, input logic halt,
                                                       input logic clear);
                if_ft_pkg::ctrl_t c;
                c.id_ready          = ready;
                c.halt_if           = halt;
                c.clear_instr_valid = clear;
                return c;
        endfunction

        function automatic if_ft_pkg::fetch_t flip_instr(input if_ft_pkg::fetch_t f,
                                                         input int bit_pos);
                if_ft_pkg::fetch_t r;
                r       = f;
                r.instr = f.instr ^ (if_ft_pkg::instr_t'(1) << bit_pos);
                return r;
        endfunction

        // Stage contents after an issue of this fetch
        function automatic if_ft_pkg::id_stage_t expect_id(input if_ft_pkg::fetch_t f);
                if_ft_pkg::id_stage_t e;
                e.instr_valid_id = 1'b1;
                e.instr          = f.instr;
                e.pc             = f.pc;
                e.is_compressed  = f.is_compressed;
                e.illegal_c      = f.illegal_c;
                e.fetch_failed   = f.fetch_failed;
                return e;
        endfunction

        // Same fetch to every replica with one instruction bit flipped in odd_rep when odd_rep >= 0
        task automatic drive_cycle(input if_ft_pkg::fetch_t f, input if_ft_pkg::ctrl_t c,
                                   input int odd_rep, input int flip_bit);
                if_ft_pkg::fetch_t [NREP-1:0] copies;
                if_ft_pkg::ctrl_t  [NREP-1:0] cvec;
                for (int k = 0; k < NREP; k++) begin
                        copies[k] = (k == odd_rep) ? flip_instr(f, flip_bit) : f;
                        cvec[k]   = c;
                end
                @(posedge clk);
                fetch_i <= copies;
                ctrl_i  <= cvec;
        endtask

        // Outputs are stable at the falling edge
        task automatic sample();
                @(negedge clk);
        endtask

        task automatic apply_reset();
                @(posedge clk);
                reset_i      <= 1'b1;
                fetch_i      <= '0;
                ctrl_i       <= '0;
                set_broken_i <= '0;
                repeat (RESET_CYCLES) @(posedge clk);
                reset_i <= 1'b0;
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Compare tasks
        ////////////////////////////////////////////////////////////////////////////

        task automatic stop_with_failure();
                $display("SOME TESTS FAILED");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic compare_id(input if_ft_pkg::id_stage_t got,
                                  input if_ft_pkg::id_stage_t exp, input string what);
                if (got !== exp) begin
                        $display("Fail at time %0t: %s, got %h, expected %h",
                                 $time, what, got, exp);
                        stop_with_failure();
                end
        endtask

        task automatic compare_mask(input if_ft_pkg::replica_mask_t got,
                                    input if_ft_pkg::replica_mask_t exp, input string what);
                if (got !== exp) begin
                        $display("Fail at time %0t: %s, got %b, expected %b",
                                 $time, what, got, exp);
                        stop_with_failure();
                end
        endtask

        task automatic compare_flag(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("Fail at time %0t: %s, got %b, expected %b",
                                 $time, what, got, exp);
                        stop_with_failure();
                end
        endtask

        task automatic check_quiet(input string what);
                compare_flag(err_detected_o, 1'b0, {what, ": err_detected_o"});
                compare_flag(err_corrected_o, 1'b0, {what, ": err_corrected_o"});
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Directed tests
        ////////////////////////////////////////////////////////////////////////////

        task automatic test_reset_state();
                apply_reset();
                sample();
                compare_id(id_o, '0, "id_o after reset");
                compare_flag(if_valid_o, 1'b0, "if_valid_o after reset");
                compare_mask(is_broken_o, '0, "is_broken_o after reset");
                check_quiet("after reset");
        endtask

        task automatic test_normal_flow();
                if_ft_pkg::fetch_t    f;
                if_ft_pkg::fetch_t    g;
                if_ft_pkg::id_stage_t cleared;
                f = random_fetch();
                g = random_fetch();
                drive_cycle(f, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                compare_flag(if_valid_o, 1'b1, "if_valid_o on issue");
                // Decode stalls while g keeps waiting on the fetch side
                drive_cycle(g, make_ctrl(1'b0, 1'b0, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(f), "id_o one cycle after issue");
                compare_flag(if_valid_o, 1'b0, "if_valid_o with id_ready low");
                drive_cycle(g, make_ctrl(1'b1, 1'b1, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(f), "id_o held with id_ready low");
                compare_flag(if_valid_o, 1'b0, "if_valid_o with halt_if high");
                drive_cycle(g, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(f), "id_o held with halt_if high");
                compare_flag(if_valid_o, 1'b1, "if_valid_o after stall");
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b1), -1, 0);
                sample();
                compare_id(id_o, expect_id(g), "id_o after stalled issue");
                compare_flag(if_valid_o, 1'b0, "if_valid_o without fetch");
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                cleared                = expect_id(g);
                cleared.instr_valid_id = 1'b0;
                compare_id(id_o, cleared, "id_o after clear_instr_valid");
                check_quiet("normal flow");
        endtask

        // One faulty issue in replica rep followed by a clean issue that overwrites it
        task automatic single_fault(input int rep);
                if_ft_pkg::fetch_t f;
                if_ft_pkg::fetch_t g;
                int                bit_pos;
                f       = random_fetch();
                g       = random_fetch();
                bit_pos = $urandom_range(if_ft_pkg::XLEN - 1, 0);
                drive_cycle(f, make_ctrl(1'b1, 1'b0, 1'b0), rep, bit_pos);
                drive_cycle(g, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(f), "majority value after single fault");
                compare_flag(err_detected_o, 1'b1, "err_detected_o after single fault");
                compare_flag(err_corrected_o, 1'b1, "err_corrected_o after single fault");
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(g), "id_o after clean issue");
                check_quiet("clean issue after fault");
        endtask

        task automatic test_leak();
                for (int r = 0; r < LEAK_ROUNDS; r++) begin
                        single_fault(2);
                        repeat (LEAK_GAP) begin
                                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                                sample();
                                compare_mask(is_broken_o, '0, "is_broken_o during leak");
                        end
                end
        endtask

        task automatic test_breakage();
                if_ft_pkg::fetch_t f;
                if_ft_pkg::fetch_t prev;
                int                waited;
                prev   = '0;
                waited = 0;
                while (!is_broken_o[1]) begin
                        if (waited == BREAK_TIMEOUT) begin
                                $display("Replica 1 not broken after %0d faulty cycles",
                                         BREAK_TIMEOUT);
                                stop_with_failure();
                        end
                        f = random_fetch();
                        drive_cycle(f, make_ctrl(1'b1, 1'b0, 1'b0), 1,
                                    $urandom_range(if_ft_pkg::XLEN - 1, 0));
                        sample();
                        if (waited > 0) begin
                                compare_id(id_o, expect_id(prev), "id_o before breakage");
                        end
                        prev   = f;
                        waited = waited + 1;
                end
                // Replica 1 is out of the vote now
                repeat (4) begin
                        f = random_fetch();
                        drive_cycle(f, make_ctrl(1'b1, 1'b0, 1'b0), 1,
                                    $urandom_range(if_ft_pkg::XLEN - 1, 0));
                        sample();
                        compare_id(id_o, expect_id(prev), "id_o with replica 1 broken");
                        check_quiet("replica 1 broken");
                        prev = f;
                end
                compare_mask(is_broken_o, if_ft_pkg::replica_mask_t'(3'b010),
                             "is_broken_o after breakage");
        endtask

        task automatic test_override_degraded();
                if_ft_pkg::fetch_t f;
                int                bit_pos;
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                set_broken_i <= if_ft_pkg::replica_mask_t'(3'b001);
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                set_broken_i <= '0;
                sample();
                compare_mask(is_broken_o, if_ft_pkg::replica_mask_t'(3'b011),
                             "is_broken_o after set_broken_i");
                // Only replica 2 is left so its word goes through as it is
                f       = random_fetch();
                bit_pos = $urandom_range(if_ft_pkg::XLEN - 1, 0);
                drive_cycle(f, make_ctrl(1'b1, 1'b0, 1'b0), 2, bit_pos);
                drive_cycle(IDLE_FETCH, make_ctrl(1'b1, 1'b0, 1'b0), -1, 0);
                sample();
                compare_id(id_o, expect_id(flip_instr(f, bit_pos)), "id_o from replica 2 alone");
                check_quiet("single healthy replica");
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Main sequence
        ////////////////////////////////////////////////////////////////////////////

        initial begin
                reset_i      = 1'b1;
                fetch_i      = '0;
                ctrl_i       = '0;
                set_broken_i = '0;
                void'($urandom(62));

                test_reset_state();
                test_normal_flow();
                single_fault(0);
                test_leak();
                test_breakage();
                test_override_degraded();

                if (UUT.u_chk.fail_count == 0) begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end else begin
                        $display("%0d assertion failures in the bound checker",
                                 UUT.u_chk.fail_count);
                        stop_with_failure();
                end
        end

endmodule

// File: bench/if_pipeline_ft_chk.sv
/* IF/ID fault tolerance assertions */

module if_pipeline_ft_chk (
        input logic                     clk,
        input logic                     reset_i,
        input if_ft_pkg::replica_mask_t broken_i,
        input logic                     err_detected_i,
        input logic                     err_corrected_i
);

        int unsigned fail_count = 0;

        // A correction always comes with a detection
        a_corrected_detected : assert property (
                @(posedge clk) disable iff (reset_i)
                err_corrected_i |-> err_detected_i
        ) else begin
                fail_count = fail_count + 1;
                $error("err_corrected_o high without err_detected_o");
        end

        // Broken flags only fall through reset
        a_broken_sticky : assert property (
                @(posedge clk)
                !$past(reset_i) |-> ((broken_i & $past(broken_i)) == $past(broken_i))
        ) else begin
                fail_count = fail_count + 1;
                $error("is_broken_o bit fell without reset");
        end

        // First cycle out of reset
        a_clean_after_reset : assert property (
                @(posedge clk)
                ($past(reset_i) && !reset_i) |->
                        (!err_detected_i && !err_corrected_i && (broken_i == '0))
        ) else begin
                fail_count = fail_count + 1;
                $error("Status flags not clear after reset");
        end

endmodule

bind if_pipeline_ft if_pipeline_ft_chk u_chk (
        .clk             (clk),
        .reset_i         (reset_i),
        .broken_i        (is_broken_o),
        .err_detected_i  (err_detected_o),
        .err_corrected_i (err_corrected_o)
);

// File: rtl/if_pipeline_ft.sv
/* Fault tolerant IF/ID pipeline top */

module if_pipeline_ft #(
        parameter int INCREMENT  = if_ft_pkg::DEF_INCREMENT,
        parameter int DECREMENT  = if_ft_pkg::DEF_DECREMENT,
        parameter int THRESHOLD  = if_ft_pkg::DEF_THRESHOLD,
        parameter int COUNT_BITS = if_ft_pkg::DEF_COUNT_BITS
) (
        input  logic                                          clk,
        input  logic                                          reset_i,

        // Triplicated inputs, one copy per replica
        input  if_ft_pkg::fetch_t [if_ft_pkg::NUM_REPLICAS-1:0] fetch_i,
        input  if_ft_pkg::ctrl_t  [if_ft_pkg::NUM_REPLICAS-1:0] ctrl_i,

        // External override of the broken flags
        input  if_ft_pkg::replica_mask_t                      set_broken_i,

        // Voted stage towards decode
        output if_ft_pkg::id_stage_t                          id_o,
        output logic                                          if_valid_o,

        // Fault tolerance status
        output if_ft_pkg::replica_mask_t                      is_broken_o,
        output logic                                          err_detected_o,
        output logic                                          err_corrected_o
);

        localparam int VOTE_WIDTH = $bits(if_ft_pkg::if_out_t);

        if_ft_pkg::if_out_t [if_ft_pkg::NUM_REPLICAS-1:0] rep_out;
        if_ft_pkg::if_out_t                               voted;
        if_ft_pkg::replica_mask_t                         block_err;

        ////////////////////////////////////////////////////////////////////////////
        // Replicas
        ////////////////////////////////////////////////////////////////////////////

        for (genvar i = 0; i < if_ft_pkg::NUM_REPLICAS; i++) begin : g_replica
                if_id_register u_if_id_register (
                        .clk     (clk),
                        .reset_i (reset_i),
                        .fetch_i (fetch_i[i]),
                        .ctrl_i  (ctrl_i[i]),
                        .out_o   (rep_out[i])
                );
        end

        ////////////////////////////////////////////////////////////////////////////
        // Voter
        ////////////////////////////////////////////////////////////////////////////

        // Whole stage voted as one vector
        tmr_voter #(
                .WIDTH (VOTE_WIDTH)
        ) u_tmr_voter (
                .rep_i           (rep_out),
                .broken_i        (is_broken_o),
                .voted_o         (voted),
                .block_err_o     (block_err),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

        assign id_o       = voted.id;
        assign if_valid_o = voted.if_valid;

        ////////////////////////////////////////////////////////////////////////////
        // Breakage monitors
        ////////////////////////////////////////////////////////////////////////////

        // One error counter per replica that feeds the voter mask
        for (genvar m = 0; m < if_ft_pkg::NUM_REPLICAS; m++) begin : g_monitor
                breakage_monitor #(
                        .INCREMENT  (INCREMENT),
                        .DECREMENT  (DECREMENT),
                        .THRESHOLD  (THRESHOLD),
                        .COUNT_BITS (COUNT_BITS)
                ) u_breakage_monitor (
                        .clk          (clk),
                        .reset_i      (reset_i),
                        .err_i        (block_err[m]),
                        .set_broken_i (set_broken_i[m]),
                        .is_broken_o  (is_broken_o[m])
                );
        end

endmodule

// File: rtl/breakage_monitor.sv
/* Replica breakage monitor */

module breakage_monitor #(
        parameter int INCREMENT  = 4,
        parameter int DECREMENT  = 1,
        parameter int THRESHOLD  = 12,
        parameter int COUNT_BITS = 5
) (
        input  logic clk,
        input  logic reset_i,
        input  logic err_i,
        input  logic set_broken_i,
        output logic is_broken_o
);

        typedef logic [COUNT_BITS-1:0] count_t;

        localparam int     COUNT_MAX = (1 << COUNT_BITS) - 1;
        localparam count_t INC       = count_t'(INCREMENT);
        localparam count_t DEC       = count_t'(DECREMENT);
        localparam count_t THR       = count_t'(THRESHOLD);
        // Above this value one more increment would wrap
        localparam count_t SAT_LIMIT = count_t'(COUNT_MAX - INCREMENT);

        count_t count_q;
        count_t count_d;
        logic   broken_q;

        ////////////////////////////////////////////////////////////////////////////
        // Leaky bucket
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                if (err_i) begin
                        count_d = (count_q > SAT_LIMIT) ? '1 : count_q + INC;
                end else if (count_q > DEC) begin
                        count_d = count_q - DEC;
                end else begin
                        count_d = '0;
                end
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        count_q  <= '0;
                        broken_q <= 1'b0;
                end else begin
                        count_q <= count_d;
                        // Sticky until reset
                        if (set_broken_i || (count_d >= THR)) begin
                                broken_q <= 1'b1;
                        end
                end
        end

        assign is_broken_o = broken_q;

endmodule

// File: rtl/tmr_voter.sv
/* Three way bitwise voter */

module tmr_voter #(
        parameter int WIDTH = 32
) (
        // One vector per replica
        input  logic [if_ft_pkg::NUM_REPLICAS-1:0][WIDTH-1:0] rep_i,

        // Replicas already declared broken
        input  if_ft_pkg::replica_mask_t                       broken_i,

        output logic [WIDTH-1:0]                               voted_o,
        output if_ft_pkg::replica_mask_t                       block_err_o,
        output logic                                           err_detected_o,
        output logic                                           err_corrected_o
);

        localparam int IDX_BITS = $clog2(if_ft_pkg::NUM_REPLICAS);

        typedef logic [WIDTH-1:0]    word_t;
        typedef logic [IDX_BITS-1:0] idx_t;
        typedef logic [IDX_BITS:0]   cnt_t;

        if_ft_pkg::replica_mask_t healthy;
        word_t                    majority;
        idx_t                     first_idx;
        cnt_t                     num_healthy;
        logic                     use_single;

        assign healthy = ~broken_i;

        ////////////////////////////////////////////////////////////////////////////
        // Healthy set
        ////////////////////////////////////////////////////////////////////////////

        // Count healthy replicas and find the lowest healthy index
        always_comb begin
                num_healthy = '0;
                first_idx   = '0;
                for (int k = if_ft_pkg::NUM_REPLICAS - 1; k >= 0; k--) begin
                        num_healthy = num_healthy + cnt_t'(healthy[k]);
                        if (healthy[k]) begin
                                first_idx = idx_t'(k);
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Vote
        ////////////////////////////////////////////////////////////////////////////

        assign majority = (rep_i[0] & rep_i[1])
                        | (rep_i[0] & rep_i[2])
                        | (rep_i[1] & rep_i[2]);

        // With one or two healthy copies no majority exists so one of them is trusted
        assign use_single = (num_healthy != '0)
                          && (num_healthy != cnt_t'(if_ft_pkg::NUM_REPLICAS));

        assign voted_o = use_single ? rep_i[first_idx] : majority;

        ////////////////////////////////////////////////////////////////////////////
        // Error reporting
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                for (int k = 0; k < if_ft_pkg::NUM_REPLICAS; k++) begin
                        block_err_o[k] = healthy[k] && (rep_i[k] != voted_o);
                end
        end

        // Any pair of healthy replicas that disagree
        always_comb begin
                err_detected_o = 1'b0;
                for (int i = 0; i < if_ft_pkg::NUM_REPLICAS; i++) begin
                        for (int j = i + 1; j < if_ft_pkg::NUM_REPLICAS; j++) begin
                                if (healthy[i] && healthy[j] && (rep_i[i] != rep_i[j])) begin
                                        err_detected_o = 1'b1;
                                end
                        end
                end
        end

        // Only a full healthy set has a real majority to correct with
        assign err_corrected_o = err_detected_o
                               && (num_healthy == cnt_t'(if_ft_pkg::NUM_REPLICAS));

endmodule

// File: rtl/if_id_register.sv
/* IF/ID pipeline register replica */

module if_id_register (
        input  logic                clk,
        input  logic                reset_i,

        // Fetch side
        input  if_ft_pkg::fetch_t   fetch_i,

        // Decode side control
        input  if_ft_pkg::ctrl_t    ctrl_i,

        // Stage contents plus issue strobe, towards the voter
        output if_ft_pkg::if_out_t  out_o
);

        ////////////////////////////////////////////////////////////////////////////
        // Issue condition
        ////////////////////////////////////////////////////////////////////////////

        logic                  issue;
        if_ft_pkg::id_stage_t  id_q;

        // A word moves into decode only when both sides agree
        assign issue = fetch_i.fetch_valid
                     & fetch_i.instr_valid
                     & ctrl_i.id_ready
                     & ~ctrl_i.halt_if;

        ////////////////////////////////////////////////////////////////////////////
        // Stage register
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        id_q <= '0;
                end else if (issue) begin
                        id_q.instr_valid_id <= 1'b1;
                        id_q.instr          <= fetch_i.instr;
                        id_q.pc             <= fetch_i.pc;
                        id_q.is_compressed  <= fetch_i.is_compressed;
                        id_q.illegal_c      <= fetch_i.illegal_c;
                        id_q.fetch_failed   <= fetch_i.fetch_failed;
                end else if (ctrl_i.clear_instr_valid) begin
                        // Flush drops the valid bit only and the payload stays
                        id_q.instr_valid_id <= 1'b0;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Outputs
        ////////////////////////////////////////////////////////////////////////////

        // if_valid is combinational and registered data follows one cycle later
        assign out_o.id       = id_q;
        assign out_o.if_valid = issue;

endmodule

// File: rtl/if_ft_pkg.sv
/* Fault tolerant IF/ID shared types */

package if_ft_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Widths
        ////////////////////////////////////////////////////////////////////////////

        // Redundant copies of the pipeline stage
        localparam int NUM_REPLICAS = 3;
        localparam int XLEN         = 32;

        typedef logic [XLEN-1:0]         instr_t;
        typedef logic [XLEN-1:0]         pc_t;
        typedef logic [NUM_REPLICAS-1:0] replica_mask_t;

        ////////////////////////////////////////////////////////////////////////////
        // Stage interfaces
        ////////////////////////////////////////////////////////////////////////////

        // Fetch side of one replica
        typedef struct packed {
                logic   instr_valid;
                logic   fetch_valid;
                instr_t instr;
                pc_t    pc;
                logic   is_compressed;
                logic   illegal_c;
                logic   fetch_failed;
        } fetch_t;

        // Decode side control of one replica
        typedef struct packed {
                logic id_ready;
                logic halt_if;
                logic clear_instr_valid;
        } ctrl_t;

        // Registered IF/ID contents
        typedef struct packed {
                logic   instr_valid_id;
                instr_t instr;
                pc_t    pc;
                logic   is_compressed;
                logic   illegal_c;
                logic   fetch_failed;
        } id_stage_t;

        // Everything one replica hands to the voter
        typedef struct packed {
                id_stage_t id;
                logic      if_valid;
        } if_out_t;

        // Breakage monitor defaults
        localparam int DEF_INCREMENT  = 4;
        localparam int DEF_DECREMENT  = 1;
        localparam int DEF_THRESHOLD  = 12;
        localparam int DEF_COUNT_BITS = 5;

endpackage
